// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_isqrt_sigcalc
FILELIST  ?= list.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, exit status gives pass or fail"
	@echo "  clean  remove the build directory obj_dir"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: isqrt_final.sv
// final correction and rounding bit extraction, last block of isqrt_sigcalc
`timescale 1ns/1ps
`include "isqrt_params.svh"

module isqrt_final (
    input  isqrt_pkg::rem_t            rem,        // last scaled error W_N
    input  isqrt_pkg::root_t           q,          // Q_N
    input  isqrt_pkg::root_t           qm,         // Q_N - ulp
    output logic [`ISQRT_SIG_WIDTH:0]  quotient,   // hidden bit and fraction
    output logic                       guard_bit,
    output logic                       round_bit,
    output logic                       sticky_bit
);

    localparam int guard_pos = `ISQRT_STEPS - `ISQRT_SIG_WIDTH - 1; // below the fraction
    localparam int round_pos = guard_pos - 1;

    isqrt_pkg::root_t root;  // truncated 1/sqrt(d)
    logic             rem_neg;

    // ------------------------------------------------------------------------
    // correction
    // ------------------------------------------------------------------------

    // W has the sign of 1/sqrt(d) - Q, negative means Q overshot by
    // less than one ulp so the truncated root is QM
    assign rem_neg = rem[`ISQRT_REM_WIDTH-1];
    assign root    = rem_neg ? qm : q;

    // ------------------------------------------------------------------------
    // field split
    // ------------------------------------------------------------------------

    assign quotient  = root[`ISQRT_STEPS -: `ISQRT_SIG_WIDTH+1]; // msb is the hidden 1
    assign guard_bit = root[guard_pos];
    assign round_bit = root[round_pos];

    // any error left means bits below round are non-zero
    assign sticky_bit = |rem;

endmodule

// File: isqrt_init.sv
// seeds the recurrence state from the aligned significand, feeds stage 0
`timescale 1ns/1ps
`include "isqrt_params.svh"

module isqrt_init (
    input  logic [`ISQRT_SIG_WIDTH+1:0] d,      // fraction bits of 0.d, 0.25 < d < 1
    output isqrt_pkg::rem_t             rem,    // W0 = 1 - d
    output isqrt_pkg::rem_t             dq,     // D0 = d * Q0
    output isqrt_pkg::rem_t             c,      // C0 = d / 2
    output isqrt_pkg::root_t            q,      // Q0
    output isqrt_pkg::root_t            qm      // QM0
);

    localparam int frac_bits = `ISQRT_REM_WIDTH - 3;          // fraction of rem_t
    localparam int pad_bits  = frac_bits - (`ISQRT_SIG_WIDTH + 2); // below the lsb of d

    // 1.0 in rem_t format
    localparam isqrt_pkg::rem_t one = {3'b001, {frac_bits{1'b0}}};

    isqrt_pkg::rem_t d_word; // d aligned to the binary point of rem_t

    // ------------------------------------------------------------------------
    // remainder words
    // ------------------------------------------------------------------------

    assign d_word = {3'b000, d, {pad_bits{1'b0}}};

    // W = 2^j * (1 - d*Q^2) at j = 0 with Q0 = 1
    assign rem = one - d_word;
    assign dq  = d_word;         // d * 1
    assign c   = d_word >>> 1;   // d * 2^-(j+1), j = 0

    // ------------------------------------------------------------------------
    // root words
    // ------------------------------------------------------------------------

    // first root estimate is exactly 1, result lies in (1, 2)
    assign q = {1'b1, {`ISQRT_STEPS{1'b0}}};

    // 1 - 2^-1, its set half bit makes the first digit's OR update exact
    // first digit is never negative since W0 > 0
    assign qm = {1'b0, 1'b1, {(`ISQRT_STEPS - 1){1'b0}}};

endmodule

// File: isqrt_params.svh
// width and pipeline macros for the inverse square root datapath, include before use
`ifndef ISQRT_PARAMS_SVH
`define ISQRT_PARAMS_SVH

// stored fraction bits of the result significand (10 half, 23 single)
`define ISQRT_SIG_WIDTH 10

// one radix-2 digit per result bit after the hidden one, guard and round included
`define ISQRT_STEPS (`ISQRT_SIG_WIDTH + 2)

// recurrence steps between two boundary registers
`define ISQRT_STEPS_PER_STAGE 4

// groups of steps, last one may be short
`define ISQRT_NUM_STAGES ((`ISQRT_STEPS + `ISQRT_STEPS_PER_STAGE - 1) / `ISQRT_STEPS_PER_STAGE)

// remainder / D / C word, 3 integer bits with sign plus a fraction wide enough
// that every shift and add of the recurrence is exact
`define ISQRT_REM_WIDTH (3 + `ISQRT_SIG_WIDTH + 2 + 2 * `ISQRT_STEPS)

`endif

// File: isqrt_pkg.sv
// digit and word types shared by the inverse square root blocks, used as isqrt_pkg::name
`include "isqrt_params.svh"

package isqrt_pkg;

    // ------------------------------------------------------------------------
    // recurrence digit
    // ------------------------------------------------------------------------

    // signed radix-2 digit, code 2'b10 never produced
    typedef enum logic [1:0] {
        DIGIT_ZERO = 2'b00, // keep Q, widen QM
        DIGIT_POS  = 2'b01, // add one ulp of this step
        DIGIT_NEG  = 2'b11  // take QM and add one ulp
    } digit_t;

    // ------------------------------------------------------------------------
    // datapath words
    // ------------------------------------------------------------------------

    // two's complement fixed point, binary point below the 3 integer bits
    // carries the scaled error W, the product D = d*Q and the term C
    typedef logic signed [`ISQRT_REM_WIDTH-1:0] rem_t;

    // partial root, integer bit on top then one bit per step
    // bit `ISQRT_STEPS weighs 2^0, bit 0 weighs 2^-`ISQRT_STEPS
    typedef logic [`ISQRT_STEPS:0] root_t;

endpackage

// File: isqrt_sigcalc.sv
// top of the inverse square root significand datapath, init -> stages -> final
`timescale 1ns/1ps
`include "isqrt_params.svh"

module isqrt_sigcalc (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        enable,     // advance the pipeline
    input  logic [`ISQRT_SIG_WIDTH+1:0] d,          // aligned significand 0.d
    output logic [`ISQRT_SIG_WIDTH:0]   quotient,
    output logic                        guard_bit,
    output logic                        round_bit,
    output logic                        sticky_bit
);

    localparam int num_stages = `ISQRT_NUM_STAGES;
    localparam int per_stage  = `ISQRT_STEPS_PER_STAGE;

    // state at each group boundary, index 0 from init, last one into final
    isqrt_pkg::rem_t  rem_b [num_stages+1];
    isqrt_pkg::rem_t  dq_b  [num_stages+1];
    isqrt_pkg::rem_t  c_b   [num_stages+1];
    isqrt_pkg::root_t q_b   [num_stages+1];
    isqrt_pkg::root_t qm_b  [num_stages+1];

    isqrt_init i_init (
        .d  (d),
        .rem(rem_b[0]), .dq(dq_b[0]), .c(c_b[0]),
        .q  (q_b[0]),   .qm(qm_b[0])
    );

    // ------------------------------------------------------------------------
    // step groups, registered at every boundary except the last
    // ------------------------------------------------------------------------

    for (genvar k = 0; k < num_stages; k++) begin : g_stage
        localparam int first = k * per_stage;
        localparam int left  = `ISQRT_STEPS - first;
        localparam int count = (left < per_stage) ? left : per_stage; // short tail group

        isqrt_stage #(
            .FIRST_STEP(first),
            .NUM_STEPS (count),
            .REGISTERED(k < num_stages - 1)
        ) i_stage (
            .clk    (clk),        .resetn (resetn),     .enable(enable),
            .rem_in (rem_b[k]),   .dq_in  (dq_b[k]),    .c_in  (c_b[k]),
            .q_in   (q_b[k]),     .qm_in  (qm_b[k]),
            .rem_out(rem_b[k+1]), .dq_out (dq_b[k+1]),  .c_out (c_b[k+1]),
            .q_out  (q_b[k+1]),   .qm_out (qm_b[k+1])
        );
    end

    // D and C of the last boundary only feed steps, final needs W and the roots
    isqrt_final i_final (
        .rem       (rem_b[num_stages]),
        .q         (q_b[num_stages]),
        .qm        (qm_b[num_stages]),
        .quotient  (quotient),
        .guard_bit (guard_bit),
        .round_bit (round_bit),
        .sticky_bit(sticky_bit)
    );

endmodule

// File: isqrt_stage.sv
// group of consecutive recurrence steps with an optional enable-gated boundary register
`timescale 1ns/1ps

module isqrt_stage #(
    parameter int FIRST_STEP = 0,   // index of the first step in this group
    parameter int NUM_STEPS  = 1,   // steps in this group
    parameter bit REGISTERED = 1'b0 // register the group output
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             enable,   // level, load while high
    input  isqrt_pkg::rem_t  rem_in,
    input  isqrt_pkg::rem_t  dq_in,
    input  isqrt_pkg::rem_t  c_in,
    input  isqrt_pkg::root_t q_in,
    input  isqrt_pkg::root_t qm_in,
    output isqrt_pkg::rem_t  rem_out,
    output isqrt_pkg::rem_t  dq_out,
    output isqrt_pkg::rem_t  c_out,
    output isqrt_pkg::root_t q_out,
    output isqrt_pkg::root_t qm_out
);

    // state between steps, index 0 is the group input
    isqrt_pkg::rem_t  rem_w [NUM_STEPS+1];
    isqrt_pkg::rem_t  dq_w  [NUM_STEPS+1];
    isqrt_pkg::rem_t  c_w   [NUM_STEPS+1];
    isqrt_pkg::root_t q_w   [NUM_STEPS+1];
    isqrt_pkg::root_t qm_w  [NUM_STEPS+1];

    assign rem_w[0] = rem_in;
    assign dq_w[0]  = dq_in;
    assign c_w[0]   = c_in;
    assign q_w[0]   = q_in;
    assign qm_w[0]  = qm_in;

    // ------------------------------------------------------------------------
    // combinational step chain
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < NUM_STEPS; i++) begin : g_step
        isqrt_step #(.STEP(FIRST_STEP + i)) i_step (
            .rem_in (rem_w[i]),   .dq_in (dq_w[i]),   .c_in (c_w[i]),
            .q_in   (q_w[i]),     .qm_in (qm_w[i]),
            .rem_out(rem_w[i+1]), .dq_out(dq_w[i+1]), .c_out(c_w[i+1]),
            .q_out  (q_w[i+1]),   .qm_out(qm_w[i+1])
        );
    end

    // ------------------------------------------------------------------------
    // boundary register
    // ------------------------------------------------------------------------

    if (REGISTERED) begin : g_reg
        always_ff @(posedge clk or negedge resetn) begin
            if (!resetn) begin
                rem_out <= '0;
                dq_out  <= '0;
                c_out   <= '0;
                q_out   <= '0;
                qm_out  <= '0;
            end else if (enable) begin
                rem_out <= rem_w[NUM_STEPS];
                dq_out  <= dq_w[NUM_STEPS];
                c_out   <= c_w[NUM_STEPS];
                q_out   <= q_w[NUM_STEPS];
                qm_out  <= qm_w[NUM_STEPS];
            end
        end

        // a stalled pipeline must hold every item in flight
        a_hold: assert property (@(posedge clk) disable iff (!resetn)
            !enable |=> $stable(rem_out) && $stable(dq_out) && $stable(c_out)
                        && $stable(q_out) && $stable(qm_out))
            else $error("isqrt_stage %0d output moved while enable was low", FIRST_STEP);
    end else begin : g_comb
        assign rem_out = rem_w[NUM_STEPS];  // last group drives final directly
        assign dq_out  = dq_w[NUM_STEPS];
        assign c_out   = c_w[NUM_STEPS];
        assign q_out   = q_w[NUM_STEPS];
        assign qm_out  = qm_w[NUM_STEPS];
    end

endmodule

// File: isqrt_step.sv
// one radix-2 inverse square root recurrence step, chained inside isqrt_stage
`timescale 1ns/1ps
`include "isqrt_params.svh"

module isqrt_step #(
    parameter int STEP = 0 // step index j, new digit weighs 2^-(j+1)
) (
    input  isqrt_pkg::rem_t  rem_in,  // W_j
    input  isqrt_pkg::rem_t  dq_in,   // D_j = d * Q_j
    input  isqrt_pkg::rem_t  c_in,    // C_j = d * 2^-(j+1)
    input  isqrt_pkg::root_t q_in,    // Q_j
    input  isqrt_pkg::root_t qm_in,   // Q_j - 2^-j
    output isqrt_pkg::rem_t  rem_out, // W_j+1
    output isqrt_pkg::rem_t  dq_out,  // D_j+1
    output isqrt_pkg::rem_t  c_out,   // C_j+1
    output isqrt_pkg::root_t q_out,   // Q_j+1
    output isqrt_pkg::root_t qm_out   // Q_j+1 - 2^-(j+1)
);

    localparam int weight_bit = `ISQRT_STEPS - STEP - 1; // root_t bit of 2^-(STEP+1)

    // one-hot at the digit position
    localparam isqrt_pkg::root_t weight = isqrt_pkg::root_t'(1) << weight_bit;

    isqrt_pkg::digit_t digit;    // selected digit
    isqrt_pkg::rem_t   rem_x2;   // 2*W
    isqrt_pkg::rem_t   dq_x2;    // 2*D
    logic signed [3:0] rem_est;  // 2*W truncated to halves

    // ------------------------------------------------------------------------
    // digit selection
    // ------------------------------------------------------------------------

    assign rem_x2  = rem_in <<< 1;  // |2W| < 4 so no overflow
    assign dq_x2   = dq_in <<< 1;
    assign rem_est = rem_x2[`ISQRT_REM_WIDTH-1 -: 4]; // 3 integer bits + 1/2 bit

    // thresholds at +1/2 and -1/2, exact on the truncated estimate
    always_comb begin
        if (rem_est >= 4'sd1) begin
            digit = isqrt_pkg::DIGIT_POS;   // 2W >= 1/2
        end else if (rem_est <= -4'sd2) begin
            digit = isqrt_pkg::DIGIT_NEG;   // 2W < -1/2
        end else begin
            digit = isqrt_pkg::DIGIT_ZERO;
        end
    end

    // ------------------------------------------------------------------------
    // remainder, D and C update with on-the-fly conversion
    // ------------------------------------------------------------------------

    // W+ = 2W - 2qD - q^2 C, D+ = D + qC
    always_comb begin
        case (digit)
            isqrt_pkg::DIGIT_POS: begin
                rem_out = rem_x2 - dq_x2 - c_in;
                dq_out  = dq_in + c_in;
                q_out   = q_in | weight;    // Q + ulp
                qm_out  = q_in;             // Q + 0
            end
            isqrt_pkg::DIGIT_NEG: begin
                rem_out = rem_x2 + dq_x2 - c_in;
                dq_out  = dq_in - c_in;
                q_out   = qm_in | weight;   // QM + ulp = Q - ulp
                qm_out  = qm_in;            // Q - 2 ulp
            end
            default: begin
                rem_out = rem_x2;           // zero digit just doubles W
                dq_out  = dq_in;
                q_out   = q_in;
                qm_out  = qm_in | weight;   // QM + ulp = Q - ulp
            end
        endcase
    end

    assign c_out = c_in >>> 1; // C is never negative

    // digit is only legal while 2W fits the word, a wrapped estimate picks the wrong one
    always_comb begin
        if (!$isunknown(rem_in)) begin
            assert final (rem_in[`ISQRT_REM_WIDTH-1] == rem_in[`ISQRT_REM_WIDTH-2])
                else $error("isqrt_step %0d remainder out of range, digit estimate wrapped",
                            STEP);
        end
    end

endmodule

// File: list.f
+incdir+.
isqrt_pkg.sv
isqrt_init.sv
isqrt_step.sv
isqrt_stage.sv
isqrt_final.sv
isqrt_sigcalc.sv
tb_isqrt_sigcalc.sv

// File: tb_isqrt_sigcalc.sv
// self-checking testbench for isqrt_sigcalc, seeded random significands against an integer model
`timescale 1ns/1ps
`include "isqrt_params.svh"

module tb_isqrt_sigcalc;

    localparam int sig_w = `ISQRT_SIG_WIDTH;
    localparam int steps = `ISQRT_STEPS;
    localparam int d_w   = sig_w + 2;
    localparam int res_w = steps + 2;                  // hidden, fraction, guard, round, sticky
    localparam int lat   = `ISQRT_NUM_STAGES - 1;      // enabled edges from d to result

    localparam int n_stream     = 2000;
    localparam int n_stall      = 300;
    localparam int max_stall    = 3;
    localparam int n_reset      = 200;
    localparam int reset_cycles = 5;

    // worst case driven cycles, stall stretches at full length
    localparam int n_vectors   = n_stream + 3 + n_stall * (1 + max_stall) + n_reset
                                 + 2 * reset_cycles + lat;
    localparam int cycle_limit = 2 * n_vectors + 100;

    localparam logic [d_w-1:0] d_min  = d_w'((1 << sig_w) + 1); // just above 0.25
    localparam logic [d_w-1:0] d_half = d_w'(1 << (sig_w + 1)); // 0.5, root is sqrt(2)
    localparam logic [d_w-1:0] d_max  = {d_w{1'b1}};

    logic             clk;
    logic             resetn;
    logic             enable;
    logic [d_w-1:0]   d;
    logic [sig_w:0]   quotient;
    logic             guard_bit;
    logic             round_bit;
    logic             sticky_bit;
    logic [res_w-1:0] dut_out;

    logic [res_w-1:0] exp_q [$];  // results in flight, oldest at the output
    logic [res_w-1:0] last_out;   // outputs seen at the previous falling edge
    logic             held;       // last edge did not load the pipeline
    int               cycles = 0;

    assign dut_out = {quotient, guard_bit, round_bit, sticky_bit};

    isqrt_sigcalc i_isqrt_sigcalc (
        .clk       (clk),
        .resetn    (resetn),
        .enable    (enable),
        .d         (d),
        .quotient  (quotient),
        .guard_bit (guard_bit),
        .round_bit (round_bit),
        .sticky_bit(sticky_bit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Test FAILED");
            $fatal(1, "run timed out after %0d cycles without finishing", cycles);
        end
    end

    // ------------------------------------------------------------------------
    // reference model and helpers
    // ------------------------------------------------------------------------

    // largest R with R^2 * D <= 2^(3*sig+6), i.e. 1/sqrt(d) truncated to steps bits
    function automatic logic [res_w-1:0] model_result(input logic [d_w-1:0] dv);
        logic [127:0] lo;
        logic [127:0] hi;
        logic [127:0] mid;
        logic [127:0] target;
        target = 128'd1 << (3 * sig_w + 6);
        lo     = 128'd1 << steps;              // root 1.0 always fits
        hi     = (128'd1 << (steps + 1)) - 1;  // root just under 2
        while (lo < hi) begin
            mid = (lo + hi + 1) >> 1;
            if (mid * mid * 128'(dv) <= target) lo = mid;
            else hi = mid - 1;
        end
        return {lo[steps:0], (lo * lo * 128'(dv) != target)}; // sticky when inexact
    endfunction

    // uniform over the open range (0.25, 1)
    function automatic logic [d_w-1:0] rand_legal();
        int unsigned span;
        span = 3 * (1 << sig_w) - 1;
        return d_w'((1 << sig_w) + 1 + ($urandom % span));
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_outputs();
        if (held && lat > 0)
            check_value(64'(dut_out), 64'(last_out), "output moved while enable was low");
        if (lat == 0 && resetn) begin
            check_value(64'(dut_out), 64'(model_result(d)), "result");   // combinational path
        end else if (lat > 0 && exp_q.size() == lat) begin
            check_value(64'(dut_out), 64'(exp_q[0]), "result");
            check_value(64'(sticky_bit), 64'd1, "sticky bit of a legal input");
        end
        last_out = dut_out;
    endtask

    // one clock: account for the edge just taken, drive the next inputs, check
    task automatic apply_cycle(input logic [d_w-1:0] d_next, input logic en_next,
                               input logic rstn_next);
        @(posedge clk);
        if (resetn && enable) begin
            exp_q.push_back(model_result(d));  // d that this edge loaded
            if (exp_q.size() > lat)
                void'(exp_q.pop_front());
        end
        held = resetn && !enable && rstn_next;
        if (!rstn_next)
            exp_q.delete();                    // registers clear, nothing left in flight
        d      <= d_next;
        enable <= en_next;
        resetn <= rstn_next;
        @(negedge clk);
        check_outputs();
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        int stall_len;
        void'($urandom(32'h154c6373));
        resetn   = 1'b0;
        enable   = 1'b0;
        d        = d_min;
        held     = 1'b0;
        last_out = '0;

        repeat (reset_cycles) apply_cycle(d_min, 1'b0, 1'b0);

        // long stream, enable high, lat items in flight
        for (int i = 0; i < n_stream; i++) apply_cycle(rand_legal(), 1'b1, 1'b1);

        // range edges
        apply_cycle(d_min, 1'b1, 1'b1);
        apply_cycle(d_half, 1'b1, 1'b1);
        apply_cycle(d_max, 1'b1, 1'b1);

        // stalls with d still moving underneath
        for (int i = 0; i < n_stall; i++) begin
            apply_cycle(rand_legal(), 1'b1, 1'b1);
            if ($urandom % 4 == 0) begin
                stall_len = 1 + int'($urandom % max_stall);
                repeat (stall_len) apply_cycle(rand_legal(), 1'b0, 1'b1);
            end
        end

        // reset halfway through a stream, enable left high
        for (int i = 0; i < n_reset / 2; i++) apply_cycle(rand_legal(), 1'b1, 1'b1);
        repeat (reset_cycles) apply_cycle(rand_legal(), 1'b1, 1'b0);
        for (int i = 0; i < n_reset / 2; i++) apply_cycle(rand_legal(), 1'b1, 1'b1);

        repeat (lat) apply_cycle(rand_legal(), 1'b1, 1'b1);   // drain

        $display("Test OK");
        $finish;
    end

endmodule
